// ==== design/tiny16_pkg.sv ====
package tiny16_pkg;

    localparam int word_width  = 16;
    localparam int stage_width = 4;

    // register indices
    localparam logic [1:0] reg_a  = 2'd0;
    localparam logic [1:0] reg_w  = 2'd1;
    localparam logic [1:0] reg_x  = 2'd2;
    localparam logic [1:0] reg_sp = 2'd3;

    // instruction register contents after reset
    localparam logic [word_width-1:0] nop_word = '1;

    // major opcodes, bits 7:4 of the word
    localparam logic [3:0] opc_jmp    = 4'h0;
    localparam logic [3:0] opc_br     = 4'h1;
    localparam logic [3:0] opc_mvh    = 4'h2;
    localparam logic [3:0] opc_movmr  = 4'h3;
    localparam logic [3:0] opc_movrm  = 4'h4;
    localparam logic [3:0] opc_sys    = 4'h5;
    localparam logic [3:0] opc_loadpc = 4'h6;
    localparam logic [3:0] opc_call   = 4'h7;
    localparam logic [3:0] opc_adi    = 4'h8;
    localparam logic [3:0] opc_andi   = 4'h9;
    localparam logic [3:0] opc_ori    = 4'hA;
    localparam logic [3:0] opc_xori   = 4'hB;

    // function codes in bits 15:8 under opc_sys
    localparam logic [7:0] opc_halt     = 8'h00;
    localparam logic [7:0] opc_wfi      = 8'h01;
    localparam logic [7:0] opc_reti     = 8'h02;
    localparam logic [7:0] opc_shr      = 8'h03;
    localparam logic [7:0] opc_shl      = 8'h04;
    localparam logic [7:0] opc_movrr    = 8'h05;
    localparam logic [7:0] opc_add      = 8'h06;
    localparam logic [7:0] opc_sub      = 8'h07;
    localparam logic [7:0] opc_and      = 8'h08;
    localparam logic [7:0] opc_or       = 8'h09;
    localparam logic [7:0] opc_xor      = 8'h0A;
    localparam logic [7:0] opc_call_reg = 8'h0B;

    // bit positions in the one-hot operation select
    localparam int op_count    = 23;
    localparam int op_jmp      = 0;
    localparam int op_br       = 1;
    localparam int op_mvh      = 2;
    localparam int op_movmr    = 3;
    localparam int op_movrm    = 4;
    localparam int op_halt     = 5;
    localparam int op_wfi      = 6;
    localparam int op_reti     = 7;
    localparam int op_shr      = 8;
    localparam int op_shl      = 9;
    localparam int op_movrr    = 10;
    localparam int op_add      = 11;
    localparam int op_sub      = 12;
    localparam int op_and      = 13;
    localparam int op_or       = 14;
    localparam int op_xor      = 15;
    localparam int op_call_reg = 16;
    localparam int op_loadpc   = 17;
    localparam int op_call     = 18;
    localparam int op_adi      = 19;
    localparam int op_andi     = 20;
    localparam int op_ori      = 21;
    localparam int op_xori     = 22;

    // one fetched word, register format or branch format
    typedef union packed {
        struct packed {
            logic [7:0] value8;
            logic [3:0] opcode;
            logic [1:0] dst;
            logic [1:0] src;
        } rr;
        struct packed {
            logic [7:0] value8;
            logic [3:0] opcode;
            logic       cond_neg;
            logic [2:0] cond;
        } cond;
    } tiny16_instr_u;

endpackage

// ==== design/tiny16_decode.sv ====
`timescale 1ns/1ps

module tiny16_decode (
    input  tiny16_pkg::tiny16_instr_u              instr,
    output logic [tiny16_pkg::op_count-1:0]        op_sel,
    output logic [1:0]                             dst,
    output logic [1:0]                             src,
    output logic [tiny16_pkg::word_width-1:0]      imm8,
    output logic [tiny16_pkg::word_width-1:0]      imm10,
    output logic [tiny16_pkg::word_width-1:0]      imm12,
    output logic [tiny16_pkg::word_width-1:0]      mvh_value,
    output logic                                   is_load,
    output logic                                   is_store,
    output logic                                   alu_imm
);
    import tiny16_pkg::*;

    logic [3:0]  major;
    logic [11:0] opcode12;
    logic [9:0]  value10;
    logic [11:0] value12;

    assign major    = instr.rr.opcode;
    // system group is identified by function code and major opcode together
    assign opcode12 = {instr.rr.value8, instr.rr.opcode};

    // wider immediates borrow the register fields as upper bits
    assign value10 = {instr.rr.src, instr.rr.value8};
    assign value12 = {instr.rr.dst, instr.rr.src, instr.rr.value8};

    assign dst = instr.rr.dst;
    assign src = instr.rr.src;

    assign imm8  = {{(word_width-8){instr.rr.value8[7]}}, instr.rr.value8};
    assign imm10 = {{(word_width-10){value10[9]}}, value10};
    assign imm12 = {{(word_width-12){value12[11]}}, value12};

    // mvh places its 10 bits at the top of the word
    assign mvh_value = {value10, {(word_width-10){1'b0}}};

    assign op_sel[op_jmp]      = (major == opc_jmp);
    assign op_sel[op_br]       = (major == opc_br);
    assign op_sel[op_mvh]      = (major == opc_mvh);
    assign op_sel[op_movmr]    = (major == opc_movmr);
    assign op_sel[op_movrm]    = (major == opc_movrm);
    assign op_sel[op_loadpc]   = (major == opc_loadpc);
    assign op_sel[op_call]     = (major == opc_call);
    assign op_sel[op_adi]      = (major == opc_adi);
    assign op_sel[op_andi]     = (major == opc_andi);
    assign op_sel[op_ori]      = (major == opc_ori);
    assign op_sel[op_xori]     = (major == opc_xori);

    assign op_sel[op_halt]     = (opcode12 == {opc_halt, opc_sys});
    assign op_sel[op_wfi]      = (opcode12 == {opc_wfi, opc_sys});
    assign op_sel[op_reti]     = (opcode12 == {opc_reti, opc_sys});
    assign op_sel[op_shr]      = (opcode12 == {opc_shr, opc_sys});
    assign op_sel[op_shl]      = (opcode12 == {opc_shl, opc_sys});
    assign op_sel[op_movrr]    = (opcode12 == {opc_movrr, opc_sys});
    assign op_sel[op_add]      = (opcode12 == {opc_add, opc_sys});
    assign op_sel[op_sub]      = (opcode12 == {opc_sub, opc_sys});
    assign op_sel[op_and]      = (opcode12 == {opc_and, opc_sys});
    assign op_sel[op_or]       = (opcode12 == {opc_or, opc_sys});
    assign op_sel[op_xor]      = (opcode12 == {opc_xor, opc_sys});
    assign op_sel[op_call_reg] = (opcode12 == {opc_call_reg, opc_sys});

    // class bits for the bus sequencer
    assign is_load  = op_sel[op_movrm] | op_sel[op_loadpc];
    assign is_store = op_sel[op_movmr] | op_sel[op_call] | op_sel[op_call_reg];
    assign alu_imm  = op_sel[op_adi] | op_sel[op_andi] | op_sel[op_ori] | op_sel[op_xori];

endmodule

// ==== design/tiny16_regfile.sv ====
`timescale 1ns/1ps

module tiny16_regfile (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [1:0]                           rsel1,
    input  logic [1:0]                           rsel2,
    output logic [tiny16_pkg::word_width-1:0]    rdata1,
    output logic [tiny16_pkg::word_width-1:0]    rdata2,
    input  logic                                 we,
    input  logic [1:0]                           wsel,
    input  logic [tiny16_pkg::word_width-1:0]    wdata
);
    import tiny16_pkg::*;

    // a, w, x, sp
    logic [word_width-1:0] regs [reg_a:reg_sp];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = reg_a; i <= reg_sp; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wsel] <= wdata;
        end
    end

    assign rdata1 = regs[rsel1];
    assign rdata2 = regs[rsel2];

endmodule

// ==== design/tiny16_core.sv ====
`timescale 1ns/1ps

module tiny16_core (
    input  logic                                 clk,
    input  logic                                 reset,
    output logic [tiny16_pkg::word_width-1:0]    address,
    input  logic [tiny16_pkg::word_width-1:0]    data_in,
    output logic [tiny16_pkg::word_width-1:0]    data_out,
    output logic                                 rd,
    output logic                                 wr,
    output logic                                 hlt,
    output logic                                 wfi,
    output logic                                 in_interrupt,
    output logic [tiny16_pkg::stage_width-1:0]   stage,
    input  logic                                 interrupt,
    output tiny16_pkg::tiny16_instr_u            instr,
    input  logic [tiny16_pkg::op_count-1:0]      op_sel,
    input  logic [1:0]                           dst,
    input  logic [1:0]                           src,
    input  logic [tiny16_pkg::word_width-1:0]    imm8,
    input  logic [tiny16_pkg::word_width-1:0]    imm10,
    input  logic [tiny16_pkg::word_width-1:0]    imm12,
    input  logic [tiny16_pkg::word_width-1:0]    mvh_value,
    input  logic                                 is_load,
    input  logic                                 is_store,
    input  logic                                 alu_imm,
    input  logic [tiny16_pkg::word_width-1:0]    src_value,
    input  logic [tiny16_pkg::word_width-1:0]    dst_value,
    output logic                                 we,
    output logic [1:0]                           wsel,
    output logic [tiny16_pkg::word_width-1:0]    wdata
);
    import tiny16_pkg::*;

    logic [word_width-1:0] pc;
    logic [word_width-1:0] saved_pc;
    logic [word_width-1:0] acc;
    logic                  carry;
    logic                  zero;
    logic                  neg;
    logic                  start;
    logic                  go;
    logic                  irq_take;
    logic                  wfi_hold;
    logic                  is_call;
    logic                  alu_rr;
    logic [2:0]            cond_hit;
    logic                  cond_pass;
    logic [word_width-1:0] pc_step;
    logic [word_width-1:0] alu_op1;
    logic [word_width-1:0] alu_op2;
    logic [word_width-1:0] src_base;
    logic [word_width-1:0] dst_base;

    assign go       = start & ~hlt;
    assign irq_take = interrupt & ~in_interrupt;
    // ring parks in stage 0001 while a wfi waits
    assign wfi_hold = go & stage[0] & ~irq_take & op_sel[op_wfi];

    assign is_call = op_sel[op_call] | op_sel[op_call_reg];
    assign alu_rr  = op_sel[op_shr] | op_sel[op_shl] | op_sel[op_add] | op_sel[op_sub]
                   | op_sel[op_and] | op_sel[op_or] | op_sel[op_xor];

    // flags come straight from the accumulator, carry is kept separately
    assign zero = (acc == '0);
    assign neg  = acc[word_width-1];

    assign cond_hit  = instr.cond.cond & {carry, zero, neg};
    assign cond_pass = (|cond_hit) ^ instr.cond.cond_neg;

    always_comb begin
        if (op_sel[op_jmp]) begin
            pc_step = imm12;
        end else if (op_sel[op_call]) begin
            pc_step = imm10;
        end else if (op_sel[op_br] && cond_pass) begin
            pc_step = imm8;
        end else begin
            pc_step = word_width'(1);
        end
    end

    assign alu_op1 = dst_value;
    assign alu_op2 = alu_imm ? imm10 : src_value;

    // base field 0 means absolute addressing
    assign src_base = (src == reg_a) ? '0 : src_value;
    assign dst_base = (dst == reg_a) ? '0 : dst_value;

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage <= stage_width'(1);
        end else if (!wfi_hold) begin
            stage <= {stage[stage_width-2:0], stage[stage_width-1]};
        end
    end

    // first full ring pass after reset is idle
    always_ff @(posedge clk) begin
        if (!reset) begin
            start <= 1'b0;
        end else if (stage[stage_width-1]) begin
            start <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            pc           <= '0;
            instr        <= nop_word;
            address      <= '0;
            hlt          <= 1'b0;
            wfi          <= 1'b0;
            in_interrupt <= 1'b0;
            acc          <= '0;
            carry        <= 1'b0;
        end else if (go) begin
            // interrupt check and fetch address
            if (stage[0]) begin
                wfi <= wfi_hold;
                if (irq_take) begin
                    in_interrupt <= 1'b1;
                    pc           <= word_width'(1);
                    address      <= word_width'(1);
                end else begin
                    address <= pc;
                end
            end
            if (stage[1]) begin
                instr <= data_in;
            end
            // execute
            if (stage[2]) begin
                hlt <= op_sel[op_halt];
                if (op_sel[op_reti]) begin
                    pc           <= saved_pc;
                    in_interrupt <= 1'b0;
                end else if (op_sel[op_call_reg]) begin
                    pc <= src_value;
                end else begin
                    pc <= pc + pc_step;
                end
                if (is_load) begin
                    address <= src_base + imm8;
                end else if (is_call) begin
                    address <= dst_value - word_width'(1);
                end else if (is_store) begin
                    address <= dst_base + imm8;
                end
                if (op_sel[op_add] || op_sel[op_adi]) begin
                    {carry, acc} <= {1'b0, alu_op1} + {1'b0, alu_op2};
                end else if (op_sel[op_sub]) begin
                    {carry, acc} <= {1'b0, alu_op1} - {1'b0, alu_op2};
                end else if (op_sel[op_shl]) begin
                    {carry, acc} <= {alu_op1, 1'b0};
                end else if (op_sel[op_shr]) begin
                    {acc, carry} <= {1'b0, alu_op1};
                end else if (op_sel[op_and] || op_sel[op_andi]) begin
                    acc <= alu_op1 & alu_op2;
                end else if (op_sel[op_or] || op_sel[op_ori]) begin
                    acc <= alu_op1 | alu_op2;
                end else if (op_sel[op_xor] || op_sel[op_xori]) begin
                    acc <= alu_op1 ^ alu_op2;
                end
            end
            if (stage[3] && op_sel[op_loadpc]) begin
                pc <= data_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go && stage[0] && irq_take) begin
            saved_pc <= pc;
        end
        // calls push the return address
        if (go && stage[2] && is_store) begin
            data_out <= is_call ? pc + word_width'(1) : src_value;
        end
    end

    assign rd = ~(go & (stage[1] | (is_load & stage[3])));
    assign wr = ~(go & is_store & stage[3]);

    // writeback in stage 1000
    assign we   = go & stage[3] & (op_sel[op_movrm] | op_sel[op_movrr] | op_sel[op_mvh]
                                   | alu_rr | alu_imm);
    assign wsel = dst;

    always_comb begin
        if (op_sel[op_movrm]) begin
            wdata = data_in;
        end else if (op_sel[op_movrr]) begin
            wdata = src_value;
        end else if (op_sel[op_mvh]) begin
            wdata = mvh_value;
        end else begin
            wdata = acc;
        end
    end

endmodule

// ==== design/tiny16_top.sv ====
`timescale 1ns/1ps

module tiny16_top (
    input  logic                                 clk,
    input  logic                                 reset,
    output logic [tiny16_pkg::word_width-1:0]    address,
    input  logic [tiny16_pkg::word_width-1:0]    data_in,
    output logic [tiny16_pkg::word_width-1:0]    data_out,
    output logic                                 rd,
    output logic                                 wr,
    output logic                                 hlt,
    output logic                                 wfi,
    output logic [tiny16_pkg::stage_width-1:0]   stage,
    input  logic                                 interrupt,
    output logic                                 in_interrupt
);
    import tiny16_pkg::*;

    tiny16_instr_u         instr;
    logic [op_count-1:0]   op_sel;
    logic [1:0]            dst;
    logic [1:0]            src;
    logic [word_width-1:0] imm8;
    logic [word_width-1:0] imm10;
    logic [word_width-1:0] imm12;
    logic [word_width-1:0] mvh_value;
    logic                  is_load;
    logic                  is_store;
    logic                  alu_imm;
    logic [word_width-1:0] src_value;
    logic [word_width-1:0] dst_value;
    logic                  we;
    logic [1:0]            wsel;
    logic [word_width-1:0] wdata;

    tiny16_core core (
        .clk          (clk),
        .reset        (reset),
        .address      (address),
        .data_in      (data_in),
        .data_out     (data_out),
        .rd           (rd),
        .wr           (wr),
        .hlt          (hlt),
        .wfi          (wfi),
        .in_interrupt (in_interrupt),
        .stage        (stage),
        .interrupt    (interrupt),
        .instr        (instr),
        .op_sel       (op_sel),
        .dst          (dst),
        .src          (src),
        .imm8         (imm8),
        .imm10        (imm10),
        .imm12        (imm12),
        .mvh_value    (mvh_value),
        .is_load      (is_load),
        .is_store     (is_store),
        .alu_imm      (alu_imm),
        .src_value    (src_value),
        .dst_value    (dst_value),
        .we           (we),
        .wsel         (wsel),
        .wdata        (wdata)
    );

    tiny16_decode decode (
        .instr     (instr),
        .op_sel    (op_sel),
        .dst       (dst),
        .src       (src),
        .imm8      (imm8),
        .imm10     (imm10),
        .imm12     (imm12),
        .mvh_value (mvh_value),
        .is_load   (is_load),
        .is_store  (is_store),
        .alu_imm   (alu_imm)
    );

    // port 1 follows src, port 2 follows dst
    tiny16_regfile regs (
        .clk    (clk),
        .reset  (reset),
        .rsel1  (src),
        .rsel2  (dst),
        .rdata1 (src_value),
        .rdata2 (dst_value),
        .we     (we),
        .wsel   (wsel),
        .wdata  (wdata)
    );

endmodule

// ==== test/tiny16_assert.sv ====
`timescale 1ns/1ps

module tiny16_assert (
    input logic                               clk,
    input logic                               reset,
    input logic                               rd,
    input logic                               wr,
    input logic                               hlt,
    input logic                               interrupt,
    input logic                               in_interrupt,
    input logic [tiny16_pkg::stage_width-1:0] stage
);

    // one strobe at a time on the shared bus
    bus_exclusive: assert property (@(posedge clk) disable iff (!reset) !(!rd && !wr))
        else $error("rd and wr are low in the same cycle");

    halt_quiet: assert property (@(posedge clk) disable iff (!reset) hlt |-> (rd && wr))
        else $error("bus strobe while halted");

    // halt is only left through reset
    halt_sticky: assert property (@(posedge clk) disable iff (!reset) hlt |=> hlt)
        else $error("hlt dropped without reset");

    irq_entry: assert property (@(posedge clk) disable iff (!reset)
        $rose(in_interrupt) |-> $past(interrupt))
        else $error("in_interrupt rose without interrupt");

    stage_onehot: assert property (@(posedge clk) disable iff (!reset) $onehot(stage))
        else $error("stage ring is not one-hot");

endmodule

bind tiny16_top tiny16_assert bus_checks (
    .clk          (clk),
    .reset        (reset),
    .rd           (rd),
    .wr           (wr),
    .hlt          (hlt),
    .interrupt    (interrupt),
    .in_interrupt (in_interrupt),
    .stage        (stage)
);

// ==== test/tiny16_tb.sv ====
`timescale 1ns/1ps

module tiny16_tb;
    import tiny16_pkg::*;

    localparam time watchdog_limit = 5 * 400 * 4 * 40;

    logic                   clk;
    logic                   reset;
    logic                   interrupt;
    logic [word_width-1:0]  address;
    logic [word_width-1:0]  data_in;
    logic [word_width-1:0]  data_out;
    logic                   rd;
    logic                   wr;
    logic                   hlt;
    logic                   wfi;
    logic                   in_interrupt;
    logic [stage_width-1:0] stage;

    logic [word_width-1:0] mem [0:1023];
    logic [word_width-1:0] log_addr [$];
    logic [word_width-1:0] log_data [$];
    logic [word_width-1:0] exp_addr [$];
    logic [word_width-1:0] exp_data [$];
    logic [15:0]           lfsr_state = 16'd49982;
    int                    prog_len;
    int                    strobe_count;

    tiny16_top dut (
        .clk          (clk),
        .reset        (reset),
        .address      (address),
        .data_in      (data_in),
        .data_out     (data_out),
        .rd           (rd),
        .wr           (wr),
        .hlt          (hlt),
        .wfi          (wfi),
        .stage        (stage),
        .interrupt    (interrupt),
        .in_interrupt (in_interrupt)
    );

    always #20 clk = ~clk;

    // combinational read while rd is low
    assign data_in = !rd ? mem[address[9:0]] : '0;

    // writes land mid-cycle, where wr and data_out are settled
    always @(negedge clk) begin
        if (reset && !wr) begin
            mem[address[9:0]] = data_out;
            log_addr.push_back(address);
            log_data.push_back(data_out);
        end
        if (reset && (!rd || !wr)) begin
            strobe_count++;
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string test, input logic [word_width-1:0] expected,
                              input logic [word_width-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
            stop_with_error("word mismatch");
        end
    endtask

    task automatic check_bit(input string test, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %b, actual %b", test, expected, actual);
            stop_with_error("status pin mismatch");
        end
    endtask

    task automatic check_stage(input string test, input logic [stage_width-1:0] expected,
                               input logic [stage_width-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %b, actual %b", test, expected, actual);
            stop_with_error("stage ring mismatch");
        end
    endtask

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_random(input int bits, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < bits; i++) begin
            value[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [15:0] instr_word(input logic [7:0] value8,
            input logic [3:0] opcode, input logic [1:0] d, input logic [1:0] s);
        return {value8, opcode, d, s};
    endfunction

    function automatic logic [15:0] sys_word(input logic [7:0] fn, input logic [1:0] d,
                                             input logic [1:0] s);
        return instr_word(fn, opc_sys, d, s);
    endfunction

    function automatic logic [15:0] branch_word(input logic [7:0] off, input logic neg,
                                                input logic [2:0] cond);
        return {off, opc_br, neg, cond};
    endfunction

    function automatic logic [15:0] store_abs(input logic [7:0] addr, input logic [1:0] s);
        return instr_word(addr, opc_movmr, reg_a, s);
    endfunction

    task automatic emit(input logic [15:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [15:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic start_program();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 16'h5A00 ^ 16'(i * 7);
        end
        exp_addr.delete();
        exp_data.delete();
        prog_len = 0;
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        reset = 1'b0;
        log_addr.delete();
        log_data.delete();
        repeat (2) @(negedge clk);
        reset = 1'b1;
    endtask

    task automatic wait_for_pin(input string test, input string pin, input int max_cycles);
        int  n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            case (pin)
                "hlt":   seen = hlt;
                "wfi":   seen = wfi;
                default: seen = !rd;
            endcase
            n++;
            if (!seen && n >= max_cycles) begin
                stop_with_error($sformatf("%s: %s never came within %0d cycles",
                                          test, pin, max_cycles));
            end
        end
    endtask

    task automatic check_writes(input string test);
        check_word(test, 16'(exp_addr.size()), 16'(log_addr.size()));
        foreach (exp_addr[i]) begin
            check_word(test, exp_addr[i], log_addr[i]);
            check_word(test, exp_data[i], log_data[i]);
        end
    endtask

    task automatic test_reset();
        start_program();
        emit(sys_word(opc_halt, reg_a, reg_a));
        pulse_reset();
        check_bit("reset", 1'b0, hlt);
        check_bit("reset", 1'b0, wfi);
        check_bit("reset", 1'b0, in_interrupt);
        check_bit("reset", 1'b1, rd);
        check_bit("reset", 1'b1, wr);
        check_stage("reset", 4'b0001, stage);
        wait_for_pin("reset", "rd", 20);
        check_word("reset", 16'h0000, address);
        check_stage("reset", 4'b0010, stage);
        wait_for_pin("reset", "hlt", 20);
    endtask

    task automatic alu_case(input logic [15:0] op_word, input logic [7:0] addr,
                            input logic [15:0] expected);
        emit(sys_word(opc_movrr, reg_a, reg_w));
        emit(op_word);
        emit(store_abs(addr, reg_a));
        expect_write({8'h00, addr}, expected);
    endtask

    task automatic test_alu();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] ext;
        take_random(16, a);
        take_random(16, b);
        take_random(10, c);
        ext = {{6{c[9]}}, c[9:0]};
        start_program();
        // mvh sets bits 15:6, adi fills in the low six
        emit(instr_word(a[13:6], opc_mvh, reg_w, a[15:14]));
        emit(instr_word({2'b00, a[5:0]}, opc_adi, reg_w, 2'b00));
        emit(instr_word(b[13:6], opc_mvh, reg_x, b[15:14]));
        emit(instr_word({2'b00, b[5:0]}, opc_adi, reg_x, 2'b00));
        alu_case(sys_word(opc_add, reg_a, reg_x), 8'h60, a + b);
        alu_case(sys_word(opc_sub, reg_a, reg_x), 8'h61, a - b);
        alu_case(sys_word(opc_and, reg_a, reg_x), 8'h62, a & b);
        alu_case(sys_word(opc_or, reg_a, reg_x), 8'h63, a | b);
        alu_case(sys_word(opc_xor, reg_a, reg_x), 8'h64, a ^ b);
        alu_case(instr_word(c[7:0], opc_adi, reg_a, c[9:8]), 8'h65, a + ext);
        alu_case(instr_word(c[7:0], opc_andi, reg_a, c[9:8]), 8'h66, a & ext);
        alu_case(instr_word(c[7:0], opc_ori, reg_a, c[9:8]), 8'h67, a | ext);
        alu_case(instr_word(c[7:0], opc_xori, reg_a, c[9:8]), 8'h68, a ^ ext);
        alu_case(sys_word(opc_shl, reg_a, reg_a), 8'h69, a << 1);
        alu_case(sys_word(opc_shr, reg_a, reg_a), 8'h6A, a >> 1);
        emit(sys_word(opc_movrr, reg_a, reg_x));
        emit(store_abs(8'h6B, reg_a));
        expect_write(16'h006B, b);
        // read back the sum through movrm
        emit(instr_word(8'h60, opc_movrm, reg_sp, reg_a));
        emit(store_abs(8'h6C, reg_sp));
        expect_write(16'h006C, a + b);
        emit(sys_word(opc_halt, reg_a, reg_a));
        pulse_reset();
        wait_for_pin("alu", "hlt", 60 * 4 + 20);
        check_writes("alu");
    endtask

    task automatic test_control();
        logic [15:0] m;
        m = 16'hA940;
        start_program();
        emit(instr_word(8'hA5, opc_mvh, reg_w, 2'b10));
        emit(instr_word(8'd2, opc_jmp, 2'b00, 2'b00));
        emit(store_abs(8'h60, reg_w));
        emit(store_abs(8'h61, reg_w));
        emit(sys_word(opc_xor, reg_a, reg_a));
        // zero set: taken, then negated not taken
        emit(branch_word(8'd2, 1'b0, 3'b010));
        emit(store_abs(8'h62, reg_w));
        emit(branch_word(8'd2, 1'b1, 3'b010));
        emit(store_abs(8'h63, reg_w));
        emit(instr_word(8'hFF, opc_adi, reg_a, 2'b11));
        emit(branch_word(8'd2, 1'b0, 3'b001));
        emit(store_abs(8'h64, reg_w));
        emit(branch_word(8'd2, 1'b0, 3'b100));
        emit(store_abs(8'h65, reg_w));
        // ffff + 1 wraps and sets carry
        emit(instr_word(8'h01, opc_adi, reg_a, 2'b00));
        emit(branch_word(8'd2, 1'b0, 3'b100));
        emit(store_abs(8'h66, reg_w));
        emit(branch_word(8'd2, 1'b1, 3'b100));
        emit(store_abs(8'h67, reg_w));
        // acc is zero here, so negative is clear
        emit(branch_word(8'd2, 1'b0, 3'b001));
        emit(store_abs(8'h6F, reg_w));
        emit(instr_word(8'h02, opc_mvh, reg_sp, 2'b00));
        emit(instr_word(8'd4, opc_call, reg_sp, 2'b00));
        emit(store_abs(8'h68, reg_w));
        emit(instr_word(8'd5, opc_jmp, 2'b00, 2'b00));
        emit(store_abs(8'h69, reg_w));
        emit(store_abs(8'h6A, reg_w));
        emit(instr_word(8'h7F, opc_loadpc, 2'b00, reg_a));
        emit(store_abs(8'h6E, reg_w));
        emit(instr_word(8'd34, opc_adi, reg_x, 2'b00));
        emit(sys_word(opc_call_reg, reg_sp, reg_x));
        emit(store_abs(8'h6B, reg_w));
        emit(sys_word(opc_halt, reg_a, reg_a));
        emit(store_abs(8'h6C, reg_w));
        emit(store_abs(8'h6D, reg_w));
        emit(instr_word(8'h7F, opc_loadpc, 2'b00, reg_a));
        expect_write(16'h0061, m);
        expect_write(16'h0063, m);
        expect_write(16'h0065, m);
        expect_write(16'h0067, m);
        expect_write(16'h006F, m);
        expect_write(16'h007F, 16'd23);
        expect_write(16'h006A, m);
        expect_write(16'h0068, m);
        expect_write(16'h007F, 16'd31);
        expect_write(16'h006D, m);
        expect_write(16'h006B, m);
        pulse_reset();
        wait_for_pin("control", "hlt", 60 * 4 + 20);
        check_writes("control");
    endtask

    task automatic test_halt();
        start_program();
        emit(instr_word(8'h33, opc_mvh, reg_w, 2'b01));
        emit(store_abs(8'h50, reg_w));
        emit(store_abs(8'h51, reg_w));
        emit(sys_word(opc_halt, reg_a, reg_a));
        emit(store_abs(8'h52, reg_w));
        expect_write(16'h0050, 16'h4CC0);
        expect_write(16'h0051, 16'h4CC0);
        pulse_reset();
        wait_for_pin("halt", "hlt", 40);
        strobe_count = 0;
        repeat (40) @(negedge clk);
        check_word("halt", 16'd0, 16'(strobe_count));
        check_bit("halt", 1'b1, hlt);
        check_writes("halt");
    endtask

    task automatic test_interrupt();
        start_program();
        emit(instr_word(8'd3, opc_jmp, 2'b00, 2'b00));
        // handler at address 1
        emit(store_abs(8'h70, reg_w));
        emit(sys_word(opc_reti, reg_a, reg_a));
        emit(instr_word(8'h55, opc_mvh, reg_w, 2'b01));
        emit(sys_word(opc_wfi, reg_a, reg_a));
        emit(store_abs(8'h71, reg_w));
        emit(sys_word(opc_halt, reg_a, reg_a));
        expect_write(16'h0070, 16'h5540);
        expect_write(16'h0071, 16'h5540);
        pulse_reset();
        wait_for_pin("interrupt", "wfi", 40);
        check_stage("interrupt", 4'b0001, stage);
        strobe_count = 0;
        repeat (20) @(negedge clk);
        check_word("interrupt", 16'd0, 16'(strobe_count));
        // ring stays parked while waiting
        check_stage("interrupt", 4'b0001, stage);
        interrupt = 1'b1;
        wait_for_pin("interrupt", "rd", 10);
        check_word("interrupt", 16'h0001, address);
        check_bit("interrupt", 1'b1, in_interrupt);
        check_bit("interrupt", 1'b0, wfi);
        interrupt = 1'b0;
        wait_for_pin("interrupt", "hlt", 40);
        check_bit("interrupt", 1'b0, in_interrupt);
        check_writes("interrupt");
    endtask

    initial begin
        #watchdog_limit;
        stop_with_error("watchdog expired, the simulation hung");
    end

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        interrupt = 1'b0;
        strobe_count = 0;
        test_reset();
        test_alu();
        test_control();
        test_halt();
        test_interrupt();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
design/tiny16_pkg.sv
design/tiny16_decode.sv
design/tiny16_regfile.sv
design/tiny16_core.sv
design/tiny16_top.sv
test/tiny16_assert.sv
test/tiny16_tb.sv

// ==== Bender.yml ====
package:
  name: tiny16

sources:
  - design/tiny16_pkg.sv
  - design/tiny16_decode.sv
  - design/tiny16_regfile.sv
  - design/tiny16_core.sv
  - design/tiny16_top.sv
  - target: test
    files:
      - test/tiny16_assert.sv
      - test/tiny16_tb.sv
